// ==== sat_macros.svh ====
`ifndef SAT_MACROS_SVH
`define SAT_MACROS_SVH

// Clause shape
`define SAT_LITS 4 // Literal cells chained in one clause
`define SAT_SLOT_W 2 // Width of a slot index into the clause

// Variable store
`define SAT_VARS 8 // Boolean variables held in the store
`define SAT_VAR_W 3 // Width of a variable index

// Free literal count, saturates at 3 which reads as three or more
`define SAT_CNT_W 2

`endif

// ==== sat_pkg.sv ====
package sat_pkg;

	// State of a variable, also used for the value of a literal
	typedef enum logic [1:0] {
		FREE = 2'd0,
		FALSE = 2'd1,
		TRUE = 2'd2,
		CONFLICT = 2'd3
	} lit_state_t;

	// Value of a literal given its variable state and its sign
	function automatic lit_state_t lit_eval(input lit_state_t state, input logic neg);
		lit_state_t val;
		case (state)
			FREE: val = FREE;
			TRUE: val = neg ? FALSE : TRUE;
			FALSE: val = neg ? TRUE : FALSE;
			default: val = FALSE; // A conflicting variable never satisfies a literal
		endcase
		return val;
	endfunction

	// Variable state that makes a literal of the given sign true
	function automatic lit_state_t lit_true_state(input logic neg);
		lit_state_t val;
		val = neg ? FALSE : TRUE;
		return val;
	endfunction

endpackage

// ==== lit_cell.sv ====
`timescale 1ns/10ps
`include "sat_macros.svh"

module lit_cell (
	input logic clk,
	input logic reset_i,
	input logic wr_i,
	input logic neg_i,
	input logic used_i,
	input sat_pkg::lit_state_t var_state_i,
	input logic [`SAT_CNT_W-1:0] freelitcnt_pre_i,
	input logic sat_pre_i,
	input logic imp_drv_i,
	input logic cclause_drv_i,
	output logic [`SAT_CNT_W-1:0] freelitcnt_next_o,
	output logic sat_next_o,
	output logic imp_valid_o,
	output sat_pkg::lit_state_t imp_state_o,
	output logic cclause_o
);

	import sat_pkg::*;

	localparam logic [`SAT_CNT_W-1:0] CNT_MAX = '1;

	logic neg_q;
	logic used_q;
	lit_state_t lit_val;
	logic lit_free;
	logic lit_true;

	// Sign of the literal, only meaningful while used_q is set
	always_ff @(posedge clk)
	begin
		if (wr_i)
		begin
			neg_q <= neg_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			used_q <= 1'b0; // Every slot starts empty
		end
		else if (wr_i)
		begin
			used_q <= used_i;
		end
	end

	assign lit_val = lit_eval(var_state_i, neg_q);
	assign lit_free = used_q && (lit_val == FREE);
	assign lit_true = used_q && (lit_val == TRUE); // Unused slot reads as false

	// Count up free literals along the chain, holding at the top value
	always_comb
	begin
		if (lit_free && (freelitcnt_pre_i != CNT_MAX))
		begin
			freelitcnt_next_o = freelitcnt_pre_i + 1'b1;
		end
		else
		begin
			freelitcnt_next_o = freelitcnt_pre_i;
		end
	end

	assign sat_next_o = sat_pre_i | lit_true;

	// In a unit clause the one free literal forces its variable
	assign imp_valid_o = imp_drv_i & lit_free;
	assign imp_state_o = lit_true_state(neg_q);

	// Mark this literal as part of a conflicting clause
	assign cclause_o = cclause_drv_i & used_q;

	// The clause only drives an implication when no literal up to here is true
	a_imp_not_true: assert property (
		@(posedge clk) disable iff (reset_i)
		imp_valid_o |-> !(sat_pre_i || lit_true)
	);

endmodule

// ==== clause_cell.sv ====
`timescale 1ns/10ps
`include "sat_macros.svh"

module clause_cell (
	input logic clk,
	input logic reset_i,
	input logic load_we_i,
	input logic [`SAT_SLOT_W-1:0] load_slot_i,
	input logic [`SAT_VAR_W-1:0] load_var_i,
	input logic load_neg_i,
	input logic load_used_i,
	input logic [`SAT_VARS*$bits(sat_pkg::lit_state_t)-1:0] var_states_i,
	output logic imp_we_o,
	output logic [`SAT_VAR_W-1:0] imp_var_o,
	output sat_pkg::lit_state_t imp_state_o,
	output logic [`SAT_CNT_W-1:0] free_count_o,
	output logic clause_sat_o,
	output logic clause_unit_o,
	output logic clause_conflict_o,
	output logic [`SAT_LITS-1:0] conflict_mask_o
);

	import sat_pkg::*;

	localparam int unsigned STATE_W = $bits(lit_state_t);

	logic [`SAT_VAR_W-1:0] slot_var_q [`SAT_LITS];
	logic [`SAT_LITS-1:0] slot_used_q;
	logic [`SAT_LITS-1:0] slot_wr;
	lit_state_t slot_state [`SAT_LITS];
	logic [`SAT_CNT_W-1:0] cnt_chain [`SAT_LITS+1];
	logic [`SAT_LITS:0] sat_chain;
	logic [`SAT_LITS-1:0] imp_valid;
	lit_state_t cell_imp_state [`SAT_LITS];
	logic imp_drv;
	logic cclause_drv;

	// Chain head starts with nothing free and nothing true
	assign cnt_chain[0] = '0;
	assign sat_chain[0] = 1'b0;

	for (genvar k = 0; k < `SAT_LITS; k++)
	begin : g_slot
		assign slot_wr[k] = load_we_i && (load_slot_i == `SAT_SLOT_W'(k));

		// Variable index of the slot, qualified by slot_used_q
		always_ff @(posedge clk)
		begin
			if (slot_wr[k])
			begin
				slot_var_q[k] <= load_var_i;
			end
		end

		// Steer the state of the slot's variable to its cell
		assign slot_state[k] = lit_state_t'(var_states_i[slot_var_q[k]*STATE_W +: STATE_W]);

		lit_cell lit_cell_i (
			.clk(clk),
			.reset_i(reset_i),
			.wr_i(slot_wr[k]),
			.neg_i(load_neg_i),
			.used_i(load_used_i),
			.var_state_i(slot_state[k]),
			.freelitcnt_pre_i(cnt_chain[k]),
			.sat_pre_i(sat_chain[k]),
			.imp_drv_i(imp_drv),
			.cclause_drv_i(cclause_drv),
			.freelitcnt_next_o(cnt_chain[k+1]),
			.sat_next_o(sat_chain[k+1]),
			.imp_valid_o(imp_valid[k]),
			.imp_state_o(cell_imp_state[k]),
			.cclause_o(conflict_mask_o[k])
		);
	end

	// Used slots, needed to tell an empty clause from a conflicting one
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			slot_used_q <= '0;
		end
		else
		begin
			for (int k = 0; k < `SAT_LITS; k++)
			begin
				if (slot_wr[k])
				begin
					slot_used_q[k] <= load_used_i;
				end
			end
		end
	end

	assign free_count_o = cnt_chain[`SAT_LITS];
	assign clause_sat_o = sat_chain[`SAT_LITS];
	assign clause_unit_o = !clause_sat_o && (free_count_o == `SAT_CNT_W'(1));
	assign clause_conflict_o = !clause_sat_o && (free_count_o == '0) && (|slot_used_q);

	assign imp_drv = clause_unit_o;
	assign cclause_drv = clause_conflict_o;

	// Pick the single cell that holds the free literal
	always_comb
	begin
		imp_var_o = '0;
		imp_state_o = FREE;
		for (int k = 0; k < `SAT_LITS; k++)
		begin
			if (imp_valid[k])
			begin
				imp_var_o = slot_var_q[k];
				imp_state_o = cell_imp_state[k];
			end
		end
	end

	assign imp_we_o = |imp_valid;

	a_one_imp: assert property (@(posedge clk) disable iff (reset_i) $onehot0(imp_valid));

	// A unit clause must find its free literal somewhere in the chain
	a_unit_drives: assert property (
		@(posedge clk) disable iff (reset_i)
		clause_unit_o |-> imp_we_o
	);

endmodule

// ==== var_base.sv ====
`timescale 1ns/10ps
`include "sat_macros.svh"

module var_base (
	input logic clk,
	input logic reset_i,
	input logic clear_i,
	input logic assign_we_i,
	input logic [`SAT_VAR_W-1:0] assign_var_i,
	input sat_pkg::lit_state_t assign_state_i,
	input logic imp_we_i,
	input logic [`SAT_VAR_W-1:0] imp_var_i,
	input sat_pkg::lit_state_t imp_state_i,
	output logic [`SAT_VARS*$bits(sat_pkg::lit_state_t)-1:0] var_states_o
);

	import sat_pkg::*;

	localparam int unsigned STATE_W = $bits(lit_state_t);

	lit_state_t states_q [`SAT_VARS];
	logic [`SAT_VARS-1:0] assign_hit;
	logic [`SAT_VARS-1:0] imp_hit;

	for (genvar v = 0; v < `SAT_VARS; v++)
	begin : g_var
		assign assign_hit[v] = assign_we_i && (assign_var_i == `SAT_VAR_W'(v));

		// Implications only land on variables that are still open
		assign imp_hit[v] = imp_we_i && (imp_var_i == `SAT_VAR_W'(v)) && (states_q[v] == FREE);

		assign var_states_o[v*STATE_W +: STATE_W] = states_q[v];
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int v = 0; v < `SAT_VARS; v++)
			begin
				states_q[v] <= FREE;
			end
		end
		else if (clear_i)
		begin
			for (int v = 0; v < `SAT_VARS; v++)
			begin
				states_q[v] <= FREE; // Clear overrides any write in the same cycle
			end
		end
		else
		begin
			for (int v = 0; v < `SAT_VARS; v++)
			begin
				if (assign_hit[v])
				begin
					states_q[v] <= assign_state_i; // Decision beats implication
				end
				else if (imp_hit[v])
				begin
					states_q[v] <= imp_state_i;
				end
			end
		end
	end

	// The clause side must always force a definite value
	a_imp_not_free: assert property (
		@(posedge clk) disable iff (reset_i)
		imp_we_i |-> (imp_state_i != FREE)
	);

endmodule

// ==== clause_engine_top.sv ====
`timescale 1ns/10ps
`include "sat_macros.svh"

module clause_engine_top (
	input logic clk,
	input logic reset_i,
	input logic clear_i,
	input logic assign_we_i,
	input logic [`SAT_VAR_W-1:0] assign_var_i,
	input sat_pkg::lit_state_t assign_state_i,
	input logic load_we_i,
	input logic [`SAT_SLOT_W-1:0] load_slot_i,
	input logic [`SAT_VAR_W-1:0] load_var_i,
	input logic load_neg_i,
	input logic load_used_i,
	output logic [`SAT_VARS*$bits(sat_pkg::lit_state_t)-1:0] var_states_o,
	output logic [`SAT_CNT_W-1:0] free_count_o,
	output logic clause_sat_o,
	output logic clause_unit_o,
	output logic clause_conflict_o,
	output logic [`SAT_LITS-1:0] conflict_mask_o
);

	import sat_pkg::*;

	logic imp_we;
	logic [`SAT_VAR_W-1:0] imp_var;
	lit_state_t imp_state;

	var_base var_base_i (
		.clk(clk),
		.reset_i(reset_i),
		.clear_i(clear_i),
		.assign_we_i(assign_we_i),
		.assign_var_i(assign_var_i),
		.assign_state_i(assign_state_i),
		.imp_we_i(imp_we),
		.imp_var_i(imp_var),
		.imp_state_i(imp_state),
		.var_states_o(var_states_o)
	);

	// The clause reads the store directly and writes implications back
	clause_cell clause_cell_i (
		.clk(clk),
		.reset_i(reset_i),
		.load_we_i(load_we_i),
		.load_slot_i(load_slot_i),
		.load_var_i(load_var_i),
		.load_neg_i(load_neg_i),
		.load_used_i(load_used_i),
		.var_states_i(var_states_o),
		.imp_we_o(imp_we),
		.imp_var_o(imp_var),
		.imp_state_o(imp_state),
		.free_count_o(free_count_o),
		.clause_sat_o(clause_sat_o),
		.clause_unit_o(clause_unit_o),
		.clause_conflict_o(clause_conflict_o),
		.conflict_mask_o(conflict_mask_o)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_o,
	output logic reset_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Reset drops a little after its last edge, in step with the other stimulus
	initial
	begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#2;
		reset_o = 1'b0;
	end

endmodule

// ==== tb_clause_engine.sv ====
`timescale 1ns/10ps
`include "sat_macros.svh"

module tb_clause_engine;

	import sat_pkg::*;

	localparam int STATE_W = $bits(lit_state_t);
	localparam int MAX_ROWS = 40;
	localparam int RESET_TIMEOUT = 10; // Cycles allowed for reset to end
	localparam int WATCHDOG_NS = 5000;

	localparam int OP_WAIT = 0;
	localparam int OP_CLEAR = 1;
	localparam int OP_LOAD = 2;
	localparam int OP_ASSIGN = 3;

	logic clk;
	logic reset;
	logic clear;
	logic assign_we;
	logic [`SAT_VAR_W-1:0] assign_var;
	lit_state_t assign_state;
	logic load_we;
	logic [`SAT_SLOT_W-1:0] load_slot;
	logic [`SAT_VAR_W-1:0] load_var;
	logic load_neg;
	logic load_used;
	logic [`SAT_VARS*STATE_W-1:0] var_states;
	logic [`SAT_CNT_W-1:0] free_count;
	logic clause_sat;
	logic clause_unit;
	logic clause_conflict;
	logic [`SAT_LITS-1:0] conflict_mask;

	int row_count;
	string row_name [MAX_ROWS];
	int row_op [MAX_ROWS];
	int row_slot [MAX_ROWS];
	int row_var [MAX_ROWS];
	logic row_neg [MAX_ROWS];
	logic row_used [MAX_ROWS];
	lit_state_t row_state [MAX_ROWS];
	int exp_cnt [MAX_ROWS];
	logic exp_sat [MAX_ROWS];
	logic exp_unit [MAX_ROWS];
	logic exp_conf [MAX_ROWS];
	logic [`SAT_LITS-1:0] exp_mask [MAX_ROWS];
	int chk_var [MAX_ROWS];
	lit_state_t chk_state [MAX_ROWS];

	tb_clock_gen tb_clock_gen_i (
		.clk_o(clk),
		.reset_o(reset)
	);

	clause_engine_top clause_engine_top_i (
		.clk(clk),
		.reset_i(reset),
		.clear_i(clear),
		.assign_we_i(assign_we),
		.assign_var_i(assign_var),
		.assign_state_i(assign_state),
		.load_we_i(load_we),
		.load_slot_i(load_slot),
		.load_var_i(load_var),
		.load_neg_i(load_neg),
		.load_used_i(load_used),
		.var_states_o(var_states),
		.free_count_o(free_count),
		.clause_sat_o(clause_sat),
		.clause_unit_o(clause_unit),
		.clause_conflict_o(clause_conflict),
		.conflict_mask_o(conflict_mask)
	);

	task automatic add_row(input string name, input int op, input int slot, input int var_idx,
		input logic neg, input logic used, input lit_state_t state, input int cnt,
		input logic sat, input logic unit, input logic conf, input logic [`SAT_LITS-1:0] mask,
		input int cvar, input lit_state_t cstate);
		row_name[row_count] = name;
		row_op[row_count] = op;
		row_slot[row_count] = slot;
		row_var[row_count] = var_idx;
		row_neg[row_count] = neg;
		row_used[row_count] = used;
		row_state[row_count] = state;
		exp_cnt[row_count] = cnt;
		exp_sat[row_count] = sat;
		exp_unit[row_count] = unit;
		exp_conf[row_count] = conf;
		exp_mask[row_count] = mask;
		chk_var[row_count] = cvar;
		chk_state[row_count] = cstate;
		row_count++;
	endtask

	// Clause under test is x1 | ~x2 | x3, later x4 joins in slot 3
	task automatic build_table;
		row_count = 0;
		// name, op, slot, var, neg, used, state, cnt, sat, unit, conf, mask, chk var, chk state
		add_row("reset_idle", OP_WAIT, 0, 0, 0, 0, FREE, 0, 0, 0, 0, 4'b0000, 1, FREE);
		add_row("park_x1", OP_ASSIGN, 0, 1, 0, 0, CONFLICT, 0, 0, 0, 0, 4'b0000, 1, CONFLICT);
		add_row("park_x2", OP_ASSIGN, 0, 2, 0, 0, CONFLICT, 0, 0, 0, 0, 4'b0000, 2, CONFLICT);
		add_row("park_x3", OP_ASSIGN, 0, 3, 0, 0, CONFLICT, 0, 0, 0, 0, 4'b0000, 3, CONFLICT);
		add_row("load_x1", OP_LOAD, 0, 1, 0, 1, FREE, 0, 0, 0, 1, 4'b0001, 1, CONFLICT);
		add_row("load_nx2", OP_LOAD, 1, 2, 1, 1, FREE, 0, 0, 0, 1, 4'b0011, 2, CONFLICT);
		add_row("load_x3", OP_LOAD, 2, 3, 0, 1, FREE, 0, 0, 0, 1, 4'b0111, 3, CONFLICT);
		add_row("clear_store", OP_CLEAR, 0, 0, 0, 0, FREE, 3, 0, 0, 0, 4'b0000, 2, FREE);
		add_row("x1_false", OP_ASSIGN, 0, 1, 0, 0, FALSE, 2, 0, 0, 0, 4'b0000, 1, FALSE);
		add_row("x3_false", OP_ASSIGN, 0, 3, 0, 0, FALSE, 1, 0, 1, 0, 4'b0000, 3, FALSE);
		add_row("imp_lands", OP_WAIT, 0, 0, 0, 0, FREE, 0, 1, 0, 0, 4'b0000, 2, FALSE);
		add_row("clear_again", OP_CLEAR, 0, 0, 0, 0, FREE, 3, 0, 0, 0, 4'b0000, 2, FREE);
		add_row("x2_false", OP_ASSIGN, 0, 2, 0, 0, FALSE, 2, 1, 0, 0, 4'b0000, 2, FALSE);
		add_row("x1_false_sat", OP_ASSIGN, 0, 1, 0, 0, FALSE, 1, 1, 0, 0, 4'b0000, 1, FALSE);
		add_row("clear_for_cf", OP_CLEAR, 0, 0, 0, 0, FREE, 3, 0, 0, 0, 4'b0000, 1, FREE);
		add_row("cf_x1_false", OP_ASSIGN, 0, 1, 0, 0, FALSE, 2, 0, 0, 0, 4'b0000, 1, FALSE);
		add_row("cf_x2_true", OP_ASSIGN, 0, 2, 0, 0, TRUE, 1, 0, 1, 0, 4'b0000, 2, TRUE);
		// Decision lands on x3 in the same edge as the implication and wins
		add_row("cf_x3_false", OP_ASSIGN, 0, 3, 0, 0, FALSE, 0, 0, 0, 1, 4'b0111, 3, FALSE);
		add_row("cf_hold", OP_WAIT, 0, 0, 0, 0, FREE, 0, 0, 0, 1, 4'b0111, 3, FALSE);
		add_row("clear_for_sat", OP_CLEAR, 0, 0, 0, 0, FREE, 3, 0, 0, 0, 4'b0000, 3, FREE);
		add_row("load_x4", OP_LOAD, 3, 4, 0, 1, FREE, 3, 0, 0, 0, 4'b0000, 4, FREE);
		add_row("sat_x1_false", OP_ASSIGN, 0, 1, 0, 0, FALSE, 3, 0, 0, 0, 4'b0000, 1, FALSE);
		add_row("sat_x3_false", OP_ASSIGN, 0, 3, 0, 0, FALSE, 2, 0, 0, 0, 4'b0000, 3, FALSE);
		add_row("sat_x4_false", OP_ASSIGN, 0, 4, 0, 0, FALSE, 1, 0, 1, 0, 4'b0000, 4, FALSE);
		add_row("imp_x2", OP_WAIT, 0, 0, 0, 0, FREE, 0, 1, 0, 0, 4'b0000, 2, FALSE);
		add_row("final_clear", OP_CLEAR, 0, 0, 0, 0, FREE, 3, 0, 0, 0, 4'b0000, 4, FREE);
		add_row("unload_x4", OP_LOAD, 3, 4, 0, 0, FREE, 3, 0, 0, 0, 4'b0000, 4, FREE);
		add_row("unload_x3", OP_LOAD, 2, 3, 0, 0, FREE, 2, 0, 0, 0, 4'b0000, 3, FREE);
		add_row("un_x1_false", OP_ASSIGN, 0, 1, 0, 0, FALSE, 1, 0, 1, 0, 4'b0000, 1, FALSE);
		add_row("un_x2_true", OP_ASSIGN, 0, 2, 0, 0, TRUE, 0, 0, 0, 1, 4'b0011, 2, TRUE);
		add_row("un_hold", OP_WAIT, 0, 0, 0, 0, FREE, 0, 0, 0, 1, 4'b0011, 3, FREE);
	endtask

	task automatic fail_value(input string name, input string what, input int expected,
		input int actual);
		$display("CHECK FAILED %s %s expected %0d actual %0d", name, what, expected, actual);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic apply_row(input int r);
		clear = 1'b0;
		assign_we = 1'b0;
		load_we = 1'b0;
		case (row_op[r])
			OP_CLEAR: clear = 1'b1;
			OP_LOAD:
			begin
				load_we = 1'b1;
				load_slot = `SAT_SLOT_W'(row_slot[r]);
				load_var = `SAT_VAR_W'(row_var[r]);
				load_neg = row_neg[r];
				load_used = row_used[r];
			end
			OP_ASSIGN:
			begin
				assign_we = 1'b1;
				assign_var = `SAT_VAR_W'(row_var[r]);
				assign_state = row_state[r];
			end
			default: ; // A wait row only lets one cycle pass
		endcase
	endtask

	task automatic check_row(input int r);
		lit_state_t seen;
		seen = lit_state_t'(var_states[chk_var[r]*STATE_W +: STATE_W]);
		assert (free_count == exp_cnt[r])
		else
		begin
			fail_value(row_name[r], "free_count_o", exp_cnt[r], free_count);
		end
		assert (clause_sat == exp_sat[r])
		else
		begin
			fail_value(row_name[r], "clause_sat_o", exp_sat[r], clause_sat);
		end
		assert (clause_unit == exp_unit[r])
		else
		begin
			fail_value(row_name[r], "clause_unit_o", exp_unit[r], clause_unit);
		end
		assert (clause_conflict == exp_conf[r])
		else
		begin
			fail_value(row_name[r], "clause_conflict_o", exp_conf[r], clause_conflict);
		end
		assert (conflict_mask == exp_mask[r])
		else
		begin
			fail_value(row_name[r], "conflict_mask_o", exp_mask[r], conflict_mask);
		end
		assert (seen == chk_state[r])
		else
		begin
			fail_value(row_name[r], $sformatf("state of x%0d", chk_var[r]), chk_state[r], seen);
		end
	endtask

	// Hard stop in case the clock or a loop never lets the run end
	initial
	begin
		#(WATCHDOG_NS);
		$display("Simulation ran past its time limit without finishing");
		$display("Test failed");
		$fatal(1);
	end

	initial
	begin
		int cycles;
		clear = 1'b0;
		assign_we = 1'b0;
		assign_var = '0;
		assign_state = FREE;
		load_we = 1'b0;
		load_slot = '0;
		load_var = '0;
		load_neg = 1'b0;
		load_used = 1'b0;
		build_table();

		// Reset may still be unknown at time zero, so wait for a clean low
		for (cycles = 0; (reset !== 1'b0) && (cycles < RESET_TIMEOUT); cycles++)
		begin
			@(posedge clk);
		end
		if (reset !== 1'b0)
		begin
			$display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
			$display("Test failed");
			$fatal(1);
		end
		@(posedge clk);
		#2;

		for (int r = 0; r < row_count; r++)
		begin
			apply_row(r);
			@(posedge clk);
			#1;
			check_row(r); // Outputs settle from the state written at this edge
			#1;
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+.
sat_pkg.sv
lit_cell.sv
clause_cell.sv
var_base.sv
clause_engine_top.sv
tb_clock_gen.sv
tb_clause_engine.sv

// ==== Bender.yml ====
package:
  name: sat_clause_engine

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - sat_pkg.sv
      - lit_cell.sv
      - clause_cell.sv
      - var_base.sv
      - clause_engine_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_clause_engine.sv
